//--- isa_pkg.sv
// ISA package with opcodes, instruction field widths and the two-view instruction word
package isa_pkg;

	localparam int instr_w   = 16;
	localparam int opcode_w  = 4;
	localparam int reg_idx_w = 3;
	localparam int imm_w     = 6;

	typedef logic [reg_idx_w-1:0] reg_idx_t;

	// Opcode map, anything above op_halt is illegal
	localparam logic [opcode_w-1:0] op_nop  = 4'd0;
	localparam logic [opcode_w-1:0] op_add  = 4'd1;
	localparam logic [opcode_w-1:0] op_sub  = 4'd2;
	localparam logic [opcode_w-1:0] op_and  = 4'd3;
	localparam logic [opcode_w-1:0] op_xor  = 4'd4;
	localparam logic [opcode_w-1:0] op_addi = 4'd5;
	localparam logic [opcode_w-1:0] op_ld   = 4'd6;
	localparam logic [opcode_w-1:0] op_st   = 4'd7;
	localparam logic [opcode_w-1:0] op_beqz = 4'd8;
	localparam logic [opcode_w-1:0] op_halt = 4'd9;

	// Same 16 bits seen as register form or immediate form
	typedef union packed {
		struct packed {
			logic [opcode_w-1:0]                        opcode;
			reg_idx_t                                   rd;
			reg_idx_t                                   rs;
			reg_idx_t                                   rt;
			logic [instr_w-opcode_w-3*reg_idx_w-1:0]    unused;
		} r;
		struct packed {
			logic [opcode_w-1:0]      opcode;
			reg_idx_t                 rd;
			reg_idx_t                 rs;
			logic signed [imm_w-1:0]  imm;
		} i;
	} instr_t;

endpackage

//--- core_pkg.sv
// Core package with data and address widths, memory depths and datapath select codes
package core_pkg;

	localparam int word_w     = 16;
	localparam int imem_depth = 256;
	localparam int dmem_depth = 256;

	// Word addresses for both memories
	localparam int pc_w    = $clog2(imem_depth);
	localparam int daddr_w = $clog2(dmem_depth);

	typedef logic [word_w-1:0] word_t;
	typedef logic [pc_w-1:0]   pc_t;

	// ALU operation select
	localparam logic [1:0] alu_add = 2'd0;
	localparam logic [1:0] alu_sub = 2'd1;
	localparam logic [1:0] alu_and = 2'd2;
	localparam logic [1:0] alu_xor = 2'd3;

	// Writeback source select
	localparam logic wb_alu = 1'b0;
	localparam logic wb_mem = 1'b1;

endpackage

//--- fetch.sv
// Fetch stage with PC, loadable instruction memory, branch redirect and the fetch/decode register
`timescale 1ns/1ps

module fetch (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              run,
	input  logic              prog_we,
	input  core_pkg::pc_t     prog_addr,
	input  core_pkg::word_t   prog_data,
	input  logic              stall,
	input  logic              stop_fetch,
	input  logic              redirect,
	input  core_pkg::pc_t     target,
	output logic              fd_valid,
	output core_pkg::pc_t     fd_pc,
	output isa_pkg::instr_t   fd_instr
);
	import core_pkg::*;
	import isa_pkg::*;

	word_t imem [imem_depth];
	pc_t   pc;
	logic  run_q;
	logic  stopped;
	logic  advance;

	// First fetch one cycle after run rises
	assign advance = run_q && !stall && !stop_fetch && !stopped;

	// Program load only while idle
	always_ff @(posedge clk) begin
		if (prog_we && !run) begin
			imem[prog_addr] <= prog_data;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			run_q    <= 1'b0;
			stopped  <= 1'b0;
			pc       <= '0;
			fd_valid <= 1'b0;
		end else if (!run) begin
			run_q    <= 1'b0;
			stopped  <= 1'b0;
			pc       <= '0;
			fd_valid <= 1'b0;
		end else begin
			run_q   <= 1'b1;
			stopped <= stopped || stop_fetch;
			if (redirect) begin
				pc       <= target;
				fd_valid <= 1'b0;
			end else begin
				if (advance) begin
					pc <= pc + 1'b1;
				end
				// Hold the stalled instruction in place
				if (!stall) begin
					fd_valid <= advance;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			fd_pc    <= pc;
			fd_instr <= instr_t'(imem[pc]);
		end
	end

endmodule

//--- decode.sv
// Decode stage with instruction decode, register file, load-use detection and decode/execute register
`timescale 1ns/1ps

module decode (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               run,
	input  logic               fd_valid,
	input  core_pkg::pc_t      fd_pc,
	input  isa_pkg::instr_t    fd_instr,
	input  logic               redirect,
	// Destination and load flag of the instruction now in execute
	input  isa_pkg::reg_idx_t  ex_mem_reg,
	input  logic               ex_mem_read,
	input  logic               wb_valid,
	input  isa_pkg::reg_idx_t  wb_reg,
	input  core_pkg::word_t    wb_data,
	output logic               stall,
	output logic               stop_fetch,
	output logic               de_valid,
	output core_pkg::pc_t      de_pc,
	output logic [1:0]         de_alu_op,
	output logic               de_use_imm,
	output logic               de_mem_read,
	output logic               de_mem_write,
	output logic               de_reg_write,
	output logic               de_is_branch,
	output logic               de_is_halt,
	output logic               de_is_illegal,
	output isa_pkg::reg_idx_t  de_rd,
	output isa_pkg::reg_idx_t  de_rs,
	output isa_pkg::reg_idx_t  de_rt,
	output core_pkg::word_t    de_a,
	output core_pkg::word_t    de_b,
	output core_pkg::word_t    de_imm
);
	import core_pkg::*;
	import isa_pkg::*;

	word_t      regs [2**reg_idx_w];
	reg_idx_t   rd;
	reg_idx_t   rs;
	reg_idx_t   rt;
	word_t      imm_ext;
	word_t      val_a;
	word_t      val_b;
	logic [1:0] alu_op;
	logic       use_imm;
	logic       mem_read;
	logic       mem_write;
	logic       reg_write;
	logic       is_branch;
	logic       is_halt;
	logic       is_illegal;
	logic       uses_rs;
	logic       uses_rt;
	logic       issue;

	assign imm_ext = {{(word_w-imm_w){fd_instr.i.imm[imm_w-1]}}, fd_instr.i.imm};

	always_comb begin
		rd         = '0;
		rs         = '0;
		rt         = '0;
		use_imm    = 1'b0;
		mem_read   = 1'b0;
		mem_write  = 1'b0;
		reg_write  = 1'b0;
		is_branch  = 1'b0;
		is_halt    = 1'b0;
		is_illegal = 1'b0;
		uses_rs    = 1'b0;
		uses_rt    = 1'b0;
		case (fd_instr.r.opcode)
			op_nop: ;
			op_add, op_sub, op_and, op_xor: begin
				rd        = fd_instr.r.rd;
				rs        = fd_instr.r.rs;
				rt        = fd_instr.r.rt;
				reg_write = 1'b1;
				uses_rs   = 1'b1;
				uses_rt   = 1'b1;
			end
			op_addi, op_ld: begin
				rd        = fd_instr.i.rd;
				rs        = fd_instr.i.rs;
				use_imm   = 1'b1;
				reg_write = 1'b1;
				mem_read  = (fd_instr.i.opcode == op_ld);
				uses_rs   = 1'b1;
			end
			// Store data comes from rd, carried on the rt read port
			op_st: begin
				rs        = fd_instr.i.rs;
				rt        = fd_instr.i.rd;
				use_imm   = 1'b1;
				mem_write = 1'b1;
				uses_rs   = 1'b1;
				uses_rt   = 1'b1;
			end
			op_beqz: begin
				rs        = fd_instr.i.rs;
				is_branch = 1'b1;
				uses_rs   = 1'b1;
			end
			op_halt: is_halt = 1'b1;
			default: is_illegal = 1'b1;
		endcase
		case (fd_instr.r.opcode)
			op_sub:  alu_op = alu_sub;
			op_and:  alu_op = alu_and;
			op_xor:  alu_op = alu_xor;
			default: alu_op = alu_add;
		endcase
	end

	// Same-cycle bypass from the writeback bus
	assign val_a = (wb_valid && wb_reg == rs) ? wb_data : regs[rs];
	assign val_b = (wb_valid && wb_reg == rt) ? wb_data : regs[rt];

	assign stall = fd_valid && ex_mem_read &&
		((uses_rs && ex_mem_reg == rs) || (uses_rt && ex_mem_reg == rt));
	assign stop_fetch = fd_valid && !redirect && (is_halt || is_illegal);
	assign issue = run && fd_valid && !redirect && !stall;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int n = 0; n < 2**reg_idx_w; n++) begin
				regs[n] <= '0;
			end
		end else if (wb_valid) begin
			regs[wb_reg] <= wb_data;
		end
	end

	// Bubble on stall, flush or idle clears every control bit
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			de_valid      <= 1'b0;
			de_mem_read   <= 1'b0;
			de_mem_write  <= 1'b0;
			de_reg_write  <= 1'b0;
			de_is_branch  <= 1'b0;
			de_is_halt    <= 1'b0;
			de_is_illegal <= 1'b0;
		end else begin
			de_valid      <= issue;
			de_mem_read   <= issue && mem_read;
			de_mem_write  <= issue && mem_write;
			de_reg_write  <= issue && reg_write;
			de_is_branch  <= issue && is_branch;
			de_is_halt    <= issue && is_halt;
			de_is_illegal <= issue && is_illegal;
		end
	end

	always_ff @(posedge clk) begin
		de_pc      <= fd_pc;
		de_alu_op  <= alu_op;
		de_use_imm <= use_imm;
		de_rd      <= rd;
		de_rs      <= rs;
		de_rt      <= rt;
		de_a       <= val_a;
		de_b       <= val_b;
		de_imm     <= imm_ext;
	end

endmodule

//--- execute.sv
// Execute stage with operand forwarding, ALU, branch resolution and the execute/memory register
`timescale 1ns/1ps

module execute (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               run,
	input  logic               de_valid,
	input  core_pkg::pc_t      de_pc,
	input  logic [1:0]         de_alu_op,
	input  logic               de_use_imm,
	input  logic               de_mem_read,
	input  logic               de_mem_write,
	input  logic               de_reg_write,
	input  logic               de_is_branch,
	input  logic               de_is_halt,
	input  logic               de_is_illegal,
	input  isa_pkg::reg_idx_t  de_rd,
	input  isa_pkg::reg_idx_t  de_rs,
	input  isa_pkg::reg_idx_t  de_rt,
	input  core_pkg::word_t    de_a,
	input  core_pkg::word_t    de_b,
	input  core_pkg::word_t    de_imm,
	input  logic               wb_valid,
	input  isa_pkg::reg_idx_t  wb_reg,
	input  core_pkg::word_t    wb_data,
	output logic               redirect,
	output core_pkg::pc_t      target,
	output logic               ex_mem_valid,
	output core_pkg::word_t    ex_mem_result,
	output core_pkg::word_t    ex_mem_store,
	output isa_pkg::reg_idx_t  ex_mem_reg,
	output logic               ex_mem_read,
	output logic               ex_mem_write,
	output logic               ex_mem_reg_write,
	output logic               ex_mem_halt,
	output logic               ex_mem_illegal
);
	import core_pkg::*;
	import isa_pkg::*;

	word_t fwd_a;
	word_t fwd_b;
	word_t op_b;
	word_t alu_y;
	logic  mem_fwd_ok;

	// A load in the memory stage still holds its address, not its data
	assign mem_fwd_ok = ex_mem_valid && ex_mem_reg_write && !ex_mem_read;

	// Newest producer wins
	function automatic word_t forward(input reg_idx_t src, input word_t reg_val);
		if (mem_fwd_ok && ex_mem_reg == src) begin
			return ex_mem_result;
		end
		if (wb_valid && wb_reg == src) begin
			return wb_data;
		end
		return reg_val;
	endfunction

	always_comb begin
		fwd_a = forward(de_rs, de_a);
		fwd_b = forward(de_rt, de_b);
	end

	assign op_b = de_use_imm ? de_imm : fwd_b;

	always_comb begin
		case (de_alu_op)
			alu_add: alu_y = fwd_a + op_b;
			alu_sub: alu_y = fwd_a - op_b;
			alu_and: alu_y = fwd_a & op_b;
			alu_xor: alu_y = fwd_a ^ op_b;
		endcase
	end

	// BEQZ taken when rs is zero
	assign redirect = de_valid && de_is_branch && (fwd_a == '0);
	assign target = de_pc + 1'b1 + de_imm[pc_w-1:0];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ex_mem_valid     <= 1'b0;
			ex_mem_read      <= 1'b0;
			ex_mem_write     <= 1'b0;
			ex_mem_reg_write <= 1'b0;
			ex_mem_halt      <= 1'b0;
			ex_mem_illegal   <= 1'b0;
		end else begin
			ex_mem_valid     <= run && de_valid;
			ex_mem_read      <= run && de_mem_read;
			ex_mem_write     <= run && de_mem_write;
			ex_mem_reg_write <= run && de_reg_write;
			ex_mem_halt      <= run && de_is_halt;
			ex_mem_illegal   <= run && de_is_illegal;
		end
	end

	always_ff @(posedge clk) begin
		ex_mem_result <= alu_y;
		ex_mem_store  <= fwd_b;
		ex_mem_reg    <= de_rd;
	end

endmodule

//--- memory.sv
// Memory stage with data memory, writeback select, memory/writeback register and halt/err flags
`timescale 1ns/1ps

module memory (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               run,
	input  logic               ex_mem_valid,
	input  core_pkg::word_t    ex_mem_result,
	input  core_pkg::word_t    ex_mem_store,
	input  isa_pkg::reg_idx_t  ex_mem_reg,
	input  logic               ex_mem_read,
	input  logic               ex_mem_write,
	input  logic               ex_mem_reg_write,
	input  logic               ex_mem_halt,
	input  logic               ex_mem_illegal,
	output logic               wb_valid,
	output isa_pkg::reg_idx_t  wb_reg,
	output core_pkg::word_t    wb_data,
	output logic               halt,
	output logic               err
);
	import core_pkg::*;

	word_t              dmem [dmem_depth];
	logic [daddr_w-1:0] addr;
	word_t              load_word;
	word_t              wb_next;
	logic               wb_sel;

	assign addr = ex_mem_result[daddr_w-1:0];
	assign load_word = dmem[addr];
	assign wb_sel = ex_mem_read ? wb_mem : wb_alu;

	always_comb begin
		case (wb_sel)
			wb_alu: wb_next = ex_mem_result;
			wb_mem: wb_next = load_word;
		endcase
	end

	// Nothing reaches memory once halted
	always_ff @(posedge clk) begin
		if (run && ex_mem_valid && ex_mem_write && !halt) begin
			dmem[addr] <= ex_mem_store;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wb_valid <= 1'b0;
			halt     <= 1'b0;
			err      <= 1'b0;
		end else if (!run) begin
			wb_valid <= 1'b0;
			halt     <= 1'b0;
			err      <= 1'b0;
		end else begin
			wb_valid <= ex_mem_valid && ex_mem_reg_write && !halt;
			// Sticky until run falls
			if (ex_mem_valid && (ex_mem_halt || ex_mem_illegal)) begin
				halt <= 1'b1;
			end
			if (ex_mem_valid && ex_mem_illegal) begin
				err <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		wb_reg  <= ex_mem_reg;
		wb_data <= wb_next;
	end

endmodule

//--- proc_core.sv
// Five-stage 16-bit processor core top level wiring fetch, decode, execute and memory
`timescale 1ns/1ps

module proc_core (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               run,
	input  logic               prog_we,
	input  core_pkg::pc_t      prog_addr,
	input  core_pkg::word_t    prog_data,
	output logic               wb_valid,
	output isa_pkg::reg_idx_t  wb_reg,
	output core_pkg::word_t    wb_data,
	output logic               halt,
	output logic               err
);
	import core_pkg::*;
	import isa_pkg::*;

	// Hazard and redirect
	logic       stall;
	logic       stop_fetch;
	logic       redirect;
	pc_t        target;

	// Fetch to decode
	logic       fd_valid;
	pc_t        fd_pc;
	instr_t     fd_instr;

	// Decode to execute
	logic       de_valid;
	pc_t        de_pc;
	logic [1:0] de_alu_op;
	logic       de_use_imm;
	logic       de_mem_read;
	logic       de_mem_write;
	logic       de_reg_write;
	logic       de_is_branch;
	logic       de_is_halt;
	logic       de_is_illegal;
	reg_idx_t   de_rd;
	reg_idx_t   de_rs;
	reg_idx_t   de_rt;
	word_t      de_a;
	word_t      de_b;
	word_t      de_imm;

	// Execute to memory
	logic       ex_mem_valid;
	word_t      ex_mem_result;
	word_t      ex_mem_store;
	reg_idx_t   ex_mem_reg;
	logic       ex_mem_read;
	logic       ex_mem_write;
	logic       ex_mem_reg_write;
	logic       ex_mem_halt;
	logic       ex_mem_illegal;

	fetch fetch_i (
		.clk, .arst_n, .run,
		.prog_we, .prog_addr, .prog_data,
		.stall, .stop_fetch, .redirect, .target,
		.fd_valid, .fd_pc, .fd_instr
	);

	// Load-use check looks at the instruction in execute
	decode decode_i (
		.clk, .arst_n, .run,
		.fd_valid, .fd_pc, .fd_instr,
		.redirect,
		.ex_mem_reg  (de_rd),
		.ex_mem_read (de_mem_read),
		.wb_valid, .wb_reg, .wb_data,
		.stall, .stop_fetch,
		.de_valid, .de_pc, .de_alu_op, .de_use_imm,
		.de_mem_read, .de_mem_write, .de_reg_write,
		.de_is_branch, .de_is_halt, .de_is_illegal,
		.de_rd, .de_rs, .de_rt, .de_a, .de_b, .de_imm
	);

	execute execute_i (
		.clk, .arst_n, .run,
		.de_valid, .de_pc, .de_alu_op, .de_use_imm,
		.de_mem_read, .de_mem_write, .de_reg_write,
		.de_is_branch, .de_is_halt, .de_is_illegal,
		.de_rd, .de_rs, .de_rt, .de_a, .de_b, .de_imm,
		.wb_valid, .wb_reg, .wb_data,
		.redirect, .target,
		.ex_mem_valid, .ex_mem_result, .ex_mem_store, .ex_mem_reg,
		.ex_mem_read, .ex_mem_write, .ex_mem_reg_write,
		.ex_mem_halt, .ex_mem_illegal
	);

	memory memory_i (
		.clk, .arst_n, .run,
		.ex_mem_valid, .ex_mem_result, .ex_mem_store, .ex_mem_reg,
		.ex_mem_read, .ex_mem_write, .ex_mem_reg_write,
		.ex_mem_halt, .ex_mem_illegal,
		.wb_valid, .wb_reg, .wb_data, .halt, .err
	);

endmodule

//--- tb_proc_core.sv
// Testbench for the five-stage core running directed programs against an instruction-set model
`timescale 1ns/1ps

module tb_proc_core;
	import core_pkg::*;
	import isa_pkg::*;

	localparam int halt_limit = 200;
	localparam int step_limit = 1000;

	logic     clk;
	logic     arst_n;
	logic     run;
	logic     prog_we;
	pc_t      prog_addr;
	word_t    prog_data;
	logic     wb_valid;
	reg_idx_t wb_reg;
	word_t    wb_data;
	logic     halt;
	logic     err;

	word_t    prog [$];
	word_t    model_regs [2**reg_idx_w];
	word_t    model_mem [dmem_depth];
	reg_idx_t exp_reg [$];
	word_t    exp_data [$];
	logic     exp_err;
	reg_idx_t got_reg [$];
	word_t    got_data [$];
	int       mismatches;
	int       failures;

	proc_core proc_core_i (
		.clk, .arst_n, .run,
		.prog_we, .prog_addr, .prog_data,
		.wb_valid, .wb_reg, .wb_data, .halt, .err
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Retire trace sampled mid-cycle
	always @(negedge clk) begin
		if (wb_valid) begin
			got_reg.push_back(wb_reg);
			got_data.push_back(wb_data);
		end
	end

	function automatic word_t reg_form(input logic [3:0] op, input reg_idx_t rd,
			input reg_idx_t rs, input reg_idx_t rt);
		instr_t w;
		w = '0;
		w.r.opcode = op;
		w.r.rd = rd;
		w.r.rs = rs;
		w.r.rt = rt;
		return word_t'(w);
	endfunction

	function automatic word_t imm_form(input logic [3:0] op, input reg_idx_t rd,
			input reg_idx_t rs, input logic [5:0] imm);
		instr_t w;
		w = '0;
		w.i.opcode = op;
		w.i.rd = rd;
		w.i.rs = rs;
		w.i.imm = imm;
		return word_t'(w);
	endfunction

	task automatic check_write(input int idx, input reg_idx_t exp_r, input word_t exp_d,
			input reg_idx_t got_r, input word_t got_d);
		if (exp_r !== got_r || exp_d !== got_d) begin
			$display("mismatch at %0t: write %0d expected r%0d=%h, got r%0d=%h",
				$time, idx, exp_r, exp_d, got_r, got_d);
			mismatches++;
		end
	endtask

	task automatic check_flag(input string what, input logic exp_bit, input logic got_bit);
		if (exp_bit !== got_bit) begin
			$display("mismatch at %0t: %s expected %b, got %b", $time, what, exp_bit, got_bit);
			mismatches++;
		end
	endtask

	task automatic record_write(input reg_idx_t rd, input word_t value);
		model_regs[rd] = value;
		exp_reg.push_back(rd);
		exp_data.push_back(value);
	endtask

	// Architectural model stepping one instruction at a time
	task automatic isa_model();
		pc_t                pc;
		pc_t                nxt;
		instr_t             ins;
		int                 imm_val;
		int                 steps;
		logic               done;
		logic [daddr_w-1:0] maddr;
		exp_reg.delete();
		exp_data.delete();
		exp_err = 1'b0;
		pc = '0;
		done = 1'b0;
		steps = 0;
		while (!done && steps < step_limit) begin
			if (int'(pc) >= prog.size()) begin
				$display("Program runs past its last word at address %0d", pc);
				failures++;
				done = 1'b1;
			end else begin
				ins = instr_t'(prog[pc]);
				imm_val = int'(ins.i.imm[4:0]) - (ins.i.imm[5] ? 32 : 0);
				maddr = daddr_w'(model_regs[ins.i.rs] + word_t'(imm_val));
				nxt = pc + 1'b1;
				case (ins.r.opcode)
					op_nop: ;
					op_add: record_write(ins.r.rd, model_regs[ins.r.rs] + model_regs[ins.r.rt]);
					op_sub: record_write(ins.r.rd, model_regs[ins.r.rs] - model_regs[ins.r.rt]);
					op_and: record_write(ins.r.rd, model_regs[ins.r.rs] & model_regs[ins.r.rt]);
					op_xor: record_write(ins.r.rd, model_regs[ins.r.rs] ^ model_regs[ins.r.rt]);
					op_addi: record_write(ins.i.rd, model_regs[ins.i.rs] + word_t'(imm_val));
					op_ld: record_write(ins.i.rd, model_mem[maddr]);
					op_st: model_mem[maddr] = model_regs[ins.i.rd];
					op_beqz: begin
						if (model_regs[ins.i.rs] == '0) begin
							nxt = pc + 1'b1 + pc_t'(imm_val);
						end
					end
					op_halt: done = 1'b1;
					default: begin
						exp_err = 1'b1;
						done = 1'b1;
					end
				endcase
				pc = nxt;
				steps++;
			end
		end
		if (!done) begin
			$display("Model never reached HALT within %0d steps", step_limit);
			failures++;
		end
	endtask

	task automatic load_program();
		int k;
		for (k = 0; k < prog.size(); k++) begin
			@(posedge clk);
			prog_we   <= 1'b1;
			prog_addr <= pc_t'(k);
			prog_data <= prog[k];
		end
		@(posedge clk);
		prog_we <= 1'b0;
	endtask

	// Load, start, wait for halt, compare the trace, then go idle
	task automatic run_program(input string name);
		int cycles;
		int k;
		isa_model();
		load_program();
		got_reg.delete();
		got_data.delete();
		@(posedge clk);
		run <= 1'b1;
		cycles = 0;
		@(negedge clk);
		while (!halt && cycles < halt_limit) begin
			@(negedge clk);
			cycles++;
		end
		if (!halt) begin
			$display("Timed out after %0d cycles waiting for halt in %s", cycles, name);
			failures++;
		end else begin
			check_flag({name, " err"}, exp_err, err);
		end
		// Window for stray writes after halt
		repeat (3) @(negedge clk);
		if (got_reg.size() != exp_reg.size()) begin
			$display("mismatch at %0t: %s retired %0d writes, expected %0d",
				$time, name, got_reg.size(), exp_reg.size());
			mismatches++;
		end
		for (k = 0; k < exp_reg.size() && k < got_reg.size(); k++) begin
			check_write(k, exp_reg[k], exp_data[k], got_reg[k], got_data[k]);
		end
		@(posedge clk);
		run <= 1'b0;
		// Flags clear on the first edge that sees run low
		repeat (2) @(negedge clk);
		check_flag({name, " halt after run falls"}, 1'b0, halt);
		check_flag({name, " err after run falls"}, 1'b0, err);
	endtask

	task automatic dependent_alu_chain();
		reg_idx_t   rd;
		reg_idx_t   prev1;
		reg_idx_t   prev2;
		logic [5:0] imm;
		int         k;
		prog.delete();
		prev1 = 3'd1;
		prev2 = 3'd2;
		for (k = 0; k < 16; k++) begin
			rd = reg_idx_t'($urandom_range(7, 0));
			imm = 6'($urandom_range(63, 0));
			case (k % 5)
				0: prog.push_back(imm_form(op_addi, rd, prev1, imm));
				1: prog.push_back(reg_form(op_add, rd, prev1, prev2));
				2: prog.push_back(reg_form(op_sub, rd, prev1, prev2));
				3: prog.push_back(reg_form(op_and, rd, prev1, prev2));
				default: prog.push_back(reg_form(op_xor, rd, prev1, prev2));
			endcase
			prev2 = prev1;
			prev1 = rd;
		end
		prog.push_back(imm_form(op_halt, '0, '0, '0));
		run_program("dependent ALU chain");
	endtask

	task automatic store_load_use();
		logic [5:0] value;
		value = 6'($urandom_range(63, 0));
		prog.delete();
		prog.push_back(reg_form(op_xor, 3'd2, 3'd2, 3'd2));
		prog.push_back(imm_form(op_addi, 3'd2, 3'd2, 6'd12));
		prog.push_back(reg_form(op_xor, 3'd3, 3'd3, 3'd3));
		prog.push_back(imm_form(op_addi, 3'd3, 3'd3, value));
		prog.push_back(imm_form(op_st, 3'd3, 3'd2, 6'd0));
		prog.push_back(imm_form(op_ld, 3'd4, 3'd2, 6'd0));
		prog.push_back(reg_form(op_add, 3'd5, 3'd4, 3'd3));
		prog.push_back(imm_form(op_st, 3'd5, 3'd2, 6'd1));
		prog.push_back(imm_form(op_ld, 3'd6, 3'd2, 6'd1));
		prog.push_back(reg_form(op_add, 3'd7, 3'd6, 3'd6));
		prog.push_back(imm_form(op_ld, 3'd1, 3'd2, 6'd0));
		// Store data taken straight from the load
		prog.push_back(imm_form(op_st, 3'd1, 3'd2, 6'd2));
		prog.push_back(imm_form(op_ld, 3'd0, 3'd2, 6'd2));
		prog.push_back(imm_form(op_halt, '0, '0, '0));
		run_program("store then load-use");
	endtask

	task automatic branch_squash();
		prog.delete();
		prog.push_back(reg_form(op_xor, 3'd1, 3'd1, 3'd1));
		prog.push_back(imm_form(op_beqz, '0, 3'd1, 6'd2));
		prog.push_back(imm_form(op_addi, 3'd2, 3'd2, 6'd5));
		prog.push_back(imm_form(op_addi, 3'd3, 3'd3, 6'd6));
		prog.push_back(imm_form(op_addi, 3'd1, 3'd1, 6'd1));
		// Not taken, rs forwarded from the previous instruction
		prog.push_back(imm_form(op_beqz, '0, 3'd1, 6'd2));
		prog.push_back(imm_form(op_addi, 3'd4, 3'd4, 6'd3));
		prog.push_back(imm_form(op_addi, 3'd5, 3'd5, 6'd4));
		prog.push_back(imm_form(op_halt, '0, '0, '0));
		run_program("taken and not-taken BEQZ");
	endtask

	task automatic halt_count();
		prog.delete();
		prog.push_back(imm_form(op_addi, 3'd1, 3'd1, 6'd3));
		prog.push_back(reg_form(op_nop, '0, '0, '0));
		prog.push_back(imm_form(op_addi, 3'd2, 3'd1, 6'h3e));
		prog.push_back(reg_form(op_add, 3'd3, 3'd1, 3'd2));
		prog.push_back(imm_form(op_halt, '0, '0, '0));
		prog.push_back(imm_form(op_addi, 3'd4, 3'd4, 6'd7));
		prog.push_back(imm_form(op_addi, 3'd5, 3'd5, 6'd9));
		run_program("HALT ends program");
	endtask

	task automatic illegal_stop();
		prog.delete();
		prog.push_back(imm_form(op_addi, 3'd1, 3'd1, 6'd1));
		prog.push_back(imm_form(op_addi, 3'd2, 3'd1, 6'd5));
		prog.push_back(imm_form(op_addi, 3'd3, 3'd2, 6'h39));
		prog.push_back(reg_form(4'hc, 3'd1, 3'd1, 3'd1));
		prog.push_back(imm_form(op_addi, 3'd4, 3'd4, 6'd1));
		prog.push_back(reg_form(op_add, 3'd5, 3'd1, 3'd2));
		prog.push_back(imm_form(op_halt, '0, '0, '0));
		run_program("illegal opcode");
	endtask

	initial begin
		arst_n     = 1'b0;
		run        = 1'b0;
		prog_we    = 1'b0;
		prog_addr  = '0;
		prog_data  = '0;
		mismatches = 0;
		failures   = 0;
		for (int n = 0; n < 2**reg_idx_w; n++) begin
			model_regs[n] = '0;
		end
		void'($urandom(32'h3bf2));
		repeat (8) @(posedge clk);
		arst_n <= 1'b1;
		@(negedge clk);
		check_flag("halt after reset", 1'b0, halt);
		check_flag("err after reset", 1'b0, err);
		check_flag("wb_valid after reset", 1'b0, wb_valid);
		dependent_alu_chain();
		store_load_use();
		branch_squash();
		halt_count();
		illegal_stop();
		repeat (2) @(posedge clk);
		$display("Closing report: %0d mismatches, %0d other failures", mismatches, failures);
		if (mismatches == 0 && failures == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

//--- verilog.f
isa_pkg.sv
core_pkg.sv
fetch.sv
decode.sv
execute.sv
memory.sv
proc_core.sv
tb_proc_core.sv

//--- run.sh
#!/bin/sh
# Build and run the core regression with Verilator, result taken from run.log
rm -rf obj_dir run.log
verilator --binary --timing -Wno-fatal --top-module tb_proc_core -f verilog.f \
	> run.log 2>&1 \
	&& ./obj_dir/Vtb_proc_core >> run.log 2>&1 \
	|| exit 1
grep -q "Regression failed" run.log && exit 1
grep -q "Regression passed" run.log || exit 1
exit 0
